// ==== rfc_pkg.sv ====
package rfc_pkg;

    // Header slicing
    localparam int CHUNK_W    = 16;
    localparam int NUM_CHUNKS = 6;

    // Table geometry
    localparam int P0_ADDR_W = 8;
    localparam int P1_ADDR_W = 10;
    localparam int RULE_W    = 16;

    typedef logic [RULE_W-1:0] rule_t;

    // All ones sorts above every real rule, so a plain minimum works
    localparam rule_t RULE_NONE = '1;

    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } header_fields_t;

    // Same 96 bits seen as fields or as six lookup chunks
    // Chunk 0 is the upper half of src_ip, chunk 5 is dst_port
    typedef union packed {
        header_fields_t                          fields;
        logic [0:NUM_CHUNKS-1][CHUNK_W-1:0]      chunks;
    } header_u;

    // Table targets for the write port
    typedef enum logic [3:0] {
        P0_C0   = 4'd0,
        P0_C1   = 4'd1,
        P0_C2   = 4'd2,
        P0_C3   = 4'd3,
        P0_C4   = 4'd4,
        P0_C5   = 4'd5,
        P1_A    = 4'd6,
        P1_B    = 4'd7,
        FINAL_T = 4'd8
    } table_sel_t;

    typedef logic [0:0] lane_id_t;

endpackage

// ==== table_write_if.sv ====
`timescale 1ns/100ps

interface table_write_if import rfc_pkg::*; ();

    // Single-cycle write strobe with its target and payload
    logic                 wr_en;
    lane_id_t             lane;
    table_sel_t           sel;
    logic [P1_ADDR_W-1:0] addr;
    logic [RULE_W-1:0]    data;

    modport src (
        output wr_en, lane, sel, addr, data
    );

    modport dst (
        input wr_en, lane, sel, addr, data
    );

endinterface

// ==== lookup_table.sv ====
`timescale 1ns/100ps

module lookup_table #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];

    // Table load port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, held while the pipeline is stalled
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== rfc_lane.sv ====
`timescale 1ns/100ps

module rfc_lane import rfc_pkg::*; #(
    parameter lane_id_t LANE_ID = 1'b0,
    parameter int SHIFT0 = 0,
    parameter int SHIFT1 = 0,
    parameter int SHIFT2 = 0,
    parameter int SHIFT3 = 0,
    parameter int SHIFT4 = 0,
    parameter int SHIFT5 = 0,
    parameter int N1 = 1,
    parameter int N3 = 1,
    parameter int N4 = 1,
    parameter int N5 = 1,
    parameter int M1 = 1
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       advance,
    input  header_u    header,
    table_write_if.dst wr,
    output rule_t      rule
);

    localparam int SHIFTS [NUM_CHUNKS] = '{SHIFT0, SHIFT1, SHIFT2, SHIFT3, SHIFT4, SHIFT5};

    localparam table_sel_t P0_SEL [NUM_CHUNKS] = '{P0_C0, P0_C1, P0_C2, P0_C3, P0_C4, P0_C5};

    header_u              header_q;
    logic [CHUNK_W-1:0]   p0_data [NUM_CHUNKS];
    logic [31:0]          key_a_sum;
    logic [31:0]          key_b_sum;
    logic [31:0]          final_sum;
    logic [P1_ADDR_W-1:0] key_a;
    logic [P1_ADDR_W-1:0] key_b;
    logic [P1_ADDR_W-1:0] final_key;
    rule_t                p1a_data;
    rule_t                p1b_data;
    logic                 lane_wr;

    // Writes addressed to this lane
    assign lane_wr = wr.wr_en && (wr.lane == LANE_ID);

    // Edge 1: header capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            header_q <= '0;
        end else if (advance) begin
            header_q <= header;
        end
    end

    // Edge 2: phase 0, one table per chunk
    for (genvar i = 0; i < NUM_CHUNKS; i++) begin : g_p0
        logic [CHUNK_W-1:0] shifted;

        // Coarser chunks drop their low bits before indexing
        assign shifted = header_q.chunks[i] >> SHIFTS[i];

        lookup_table #(
            .ADDR_W (P0_ADDR_W),
            .DATA_W (CHUNK_W)
        ) u_tbl (
            .clk     (clk),
            .rd_en   (advance),
            .rd_addr (shifted[P0_ADDR_W-1:0]),
            .rd_data (p0_data[i]),
            .wr_en   (lane_wr && (wr.sel == P0_SEL[i])),
            .wr_addr (wr.addr[P0_ADDR_W-1:0]),
            .wr_data (wr.data)
        );
    end

    // Equivalence-class products, reduced to the table size below
    assign key_a_sum = p0_data[0] * N1 * N5 + p0_data[1] * N5 + p0_data[5];
    assign key_b_sum = p0_data[2] * N3 * N4 + p0_data[3] * N4 + p0_data[4];

    // Edge 3: phase-1 keys
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_a <= '0;
            key_b <= '0;
        end else if (advance) begin
            key_a <= key_a_sum[P1_ADDR_W-1:0];
            key_b <= key_b_sum[P1_ADDR_W-1:0];
        end
    end

    // Edge 4: phase-1 lookups
    lookup_table #(
        .ADDR_W (P1_ADDR_W),
        .DATA_W (RULE_W)
    ) u_p1a (
        .clk     (clk),
        .rd_en   (advance),
        .rd_addr (key_a),
        .rd_data (p1a_data),
        .wr_en   (lane_wr && (wr.sel == P1_A)),
        .wr_addr (wr.addr),
        .wr_data (wr.data)
    );

    lookup_table #(
        .ADDR_W (P1_ADDR_W),
        .DATA_W (RULE_W)
    ) u_p1b (
        .clk     (clk),
        .rd_en   (advance),
        .rd_addr (key_b),
        .rd_data (p1b_data),
        .wr_en   (lane_wr && (wr.sel == P1_B)),
        .wr_addr (wr.addr),
        .wr_data (wr.data)
    );

    assign final_sum = p1a_data * M1 + p1b_data;

    // Edge 5: final key
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            final_key <= '0;
        end else if (advance) begin
            final_key <= final_sum[P1_ADDR_W-1:0];
        end
    end

    // Edge 6: rule lookup, its output is the lane result
    lookup_table #(
        .ADDR_W (P1_ADDR_W),
        .DATA_W (RULE_W)
    ) u_final (
        .clk     (clk),
        .rd_en   (advance),
        .rd_addr (final_key),
        .rd_data (rule),
        .wr_en   (lane_wr && (wr.sel == FINAL_T)),
        .wr_addr (wr.addr),
        .wr_data (wr.data)
    );

endmodule

// ==== match_select.sv ====
`timescale 1ns/100ps

module match_select import rfc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  packet_valid,
    output logic  packet_ready,
    output logic  advance,
    input  rule_t rule_a,
    input  rule_t rule_b,
    output logic  result_valid,
    output rule_t result,
    input  logic  result_ready
);

    // Lane depth from header capture to rule read data
    localparam int LANE_LATENCY = 6;

    logic [LANE_LATENCY-1:0] valid_pipe;
    logic                    accept;
    rule_t                   min_rule;

    // Whole pipeline moves unless a result is waiting on the consumer
    assign advance      = !result_valid || result_ready;
    assign packet_ready = advance;
    assign accept       = packet_valid && packet_ready;

    // No-match is all ones, so it only survives when both lanes miss
    assign min_rule = (rule_a < rule_b) ? rule_a : rule_b;

    // Valid bits shadow the lane stages one for one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else if (advance) begin
            valid_pipe <= {valid_pipe[LANE_LATENCY-2:0], accept};
        end
    end

    // Edge 7: output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result       <= RULE_NONE;
        end else if (advance) begin
            result_valid <= valid_pipe[LANE_LATENCY-1];
            if (valid_pipe[LANE_LATENCY-1]) begin
                result <= min_rule;
            end
        end
    end

endmodule

// ==== rfc_classifier.sv ====
`timescale 1ns/100ps

module rfc_classifier import rfc_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 packet_valid,
    input  logic [31:0]          src_ip,
    input  logic [31:0]          dst_ip,
    input  logic [15:0]          src_port,
    input  logic [15:0]          dst_port,
    output logic                 packet_ready,

    output logic                 result_valid,
    output rule_t                result,
    input  logic                 result_ready,

    input  logic                 tbl_wr_en,
    input  lane_id_t             tbl_lane,
    input  table_sel_t           tbl_sel,
    input  logic [P1_ADDR_W-1:0] tbl_addr,
    input  logic [RULE_W-1:0]    tbl_data
);

    header_u header;
    logic    advance;
    rule_t   rule_a;
    rule_t   rule_b;

    table_write_if tbl_wr ();

    assign tbl_wr.wr_en = tbl_wr_en;
    assign tbl_wr.lane  = tbl_lane;
    assign tbl_wr.sel   = tbl_sel;
    assign tbl_wr.addr  = tbl_addr;
    assign tbl_wr.data  = tbl_data;

    assign header.fields = '{src_ip: src_ip, dst_ip: dst_ip,
                             src_port: src_port, dst_port: dst_port};

    // Coarse prefix lane, dst_ip low chunk collapses to one class
    rfc_lane #(
        .LANE_ID (1'b0),
        .SHIFT0 (0), .SHIFT1 (4), .SHIFT2 (1), .SHIFT3 (16), .SHIFT4 (0), .SHIFT5 (0),
        .N1 (5), .N3 (1), .N4 (1), .N5 (4), .M1 (8)
    ) lane_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .header  (header),
        .wr      (tbl_wr),
        .rule    (rule_a)
    );

    rfc_lane #(
        .LANE_ID (1'b1),
        .SHIFT0 (0), .SHIFT1 (4), .SHIFT2 (0), .SHIFT3 (0), .SHIFT4 (0), .SHIFT5 (0),
        .N1 (5), .N3 (2), .N4 (1), .N5 (3), .M1 (6)
    ) lane_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .header  (header),
        .wr      (tbl_wr),
        .rule    (rule_b)
    );

    match_select u_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .packet_valid (packet_valid),
        .packet_ready (packet_ready),
        .advance      (advance),
        .rule_a       (rule_a),
        .rule_b       (rule_b),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready)
    );

endmodule

// ==== rfc_classifier_props.sv ====
`timescale 1ns/100ps

module rfc_classifier_props import rfc_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  packet_ready,
    input logic  result_valid,
    input rule_t result,
    input logic  result_ready,
    input rule_t rule_a,
    input rule_t rule_b
);

    // A stalled result stays put until taken
    assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid && !result_ready) |=> (result_valid && $stable(result)))
        else $error("result changed or dropped while stalled");

    // A blocked output closes the input and freezes both lanes
    assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid && !result_ready) |=>
            (!$past(packet_ready) && $stable(rule_a) && $stable(rule_b)))
        else $error("input open or lanes moved while output stalled");

endmodule

bind rfc_classifier rfc_classifier_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .packet_ready (packet_ready),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready),
    .rule_a       (rule_a),
    .rule_b       (rule_b)
);

// ==== tb_rfc_classifier.sv ====
`timescale 1ns/100ps

module tb_rfc_classifier import rfc_pkg::*; ();

    logic       clk = 1'b0;
    logic       rst_n;
    logic       packet_valid;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic       packet_ready;
    logic       result_valid;
    rule_t      result;
    logic       result_ready;
    logic       tbl_wr_en;
    lane_id_t   tbl_lane;
    table_sel_t tbl_sel;
    logic [P1_ADDR_W-1:0] tbl_addr;
    logic [RULE_W-1:0]    tbl_data;

    logic [30:0]  writes [$];
    logic [111:0] packets [$];
    rule_t        expected [$];
    int           value_errors = 0;
    int           protocol_errors = 0;
    int           cycles = 0;
    int           limit = 1000000;
    int           first_accept = -1;
    bit           seen_valid = 0;
    bit           random_ready = 0;
    logic [31:0]  rng = 32'hc15c_9d19;

    rfc_classifier dut0 (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check_rule(input string what, input rule_t got, input rule_t exp);
        if (got !== exp) begin
            $display("Fail %0t: %s rule %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] f [5];
        fd = $fopen("rfc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            protocol_errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%c %h %h %h %h %h", kind, f[0], f[1], f[2], f[3], f[4]);
            if (kind == "W")
                writes.push_back({f[0][0], f[1][3:0], f[2][9:0], f[3][15:0]});
            else if (kind == "P")
                packets.push_back({f[0], f[1], f[2][15:0], f[3][15:0], f[4][15:0]});
        end
        $fclose(fd);
    endtask

    task automatic write_table(input logic [30:0] w);
        tbl_wr_en = 1'b1;
        tbl_lane  = w[30];
        tbl_sel   = table_sel_t'(w[29:26]);
        tbl_addr  = w[25:16];
        tbl_data  = w[15:0];
        @(posedge clk);
        #1;
        tbl_wr_en = 1'b0;
    endtask

    // Called 1 ns after an edge and returns 1 ns after the acceptance edge
    task automatic send_packet(input logic [111:0] p);
        packet_valid = 1'b1;
        {src_ip, dst_ip, src_port, dst_port} = p[111:16];
        expected.push_back(p[15:0]);
        @(negedge clk);
        while (!packet_ready) @(negedge clk);
        @(posedge clk);
        #1;
        packet_valid = 1'b0;
    endtask

    task automatic drain();
        while (expected.size() != 0) @(posedge clk);
        #1;
    endtask

    // Cycle count and run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout: results still outstanding after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    always @(posedge clk) begin
        #1;
        if (random_ready) begin
            rng = xorshift32(rng);
            result_ready = rng[3];
        end else begin
            result_ready = 1'b1;
        end
    end

    // Inputs move 1 ns after an edge so the negedge view is stable
    always @(negedge clk) begin
        if (rst_n) begin
            if (packet_valid && packet_ready && first_accept < 0) first_accept = cycles + 1;
            // The acceptance edge counts as edge 1
            if (result_valid && !seen_valid) begin
                seen_valid = 1;
                if (cycles - first_accept + 1 != 7) begin
                    $display("Fail %0t: first result at edge %0d, expected edge 7",
                             $time, cycles - first_accept + 1);
                    value_errors++;
                end
            end
            // Back-to-back packets with a ready consumer leave no gaps
            if (!random_ready && seen_valid && !result_valid && expected.size() != 0) begin
                $display("Result stream paused with results outstanding at %0t", $time);
                protocol_errors++;
            end
            if (result_valid && result_ready) begin
                if (expected.size() == 0) begin
                    $display("A result arrived with no packet outstanding at %0t", $time);
                    protocol_errors++;
                end else begin
                    check_rule("result", result, expected.pop_front());
                end
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        packet_valid = 1'b0;
        src_ip = '0;
        dst_ip = '0;
        src_port = '0;
        dst_port = '0;
        result_ready = 1'b1;
        tbl_wr_en = 1'b0;
        tbl_lane = '0;
        tbl_sel = P0_C0;
        tbl_addr = '0;
        tbl_data = '0;
        load_stimulus();
        limit = (writes.size() + packets.size() + 7) * 4 + 200;

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("result_valid after reset", result_valid, 1'b0);
        check_flag("packet_ready after reset", packet_ready, 1'b1);
        check_rule("reset", result, RULE_NONE);
        @(posedge clk);
        #1;

        foreach (writes[i]) write_table(writes[i]);

        // Back to back with the consumer always ready
        foreach (packets[i]) send_packet(packets[i]);
        drain();

        // Same packets under random back-pressure
        random_ready = 1;
        foreach (packets[i]) send_packet(packets[i]);
        drain();
        repeat (4) @(posedge clk);

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rfc_pkg.sv
table_write_if.sv
lookup_table.sv
rfc_lane.sv
match_select.sv
rfc_classifier.sv
rfc_classifier_props.sv
tb_rfc_classifier.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f sim.f \
    --top-module tb_rfc_classifier \
    -o tb_rfc_classifier

./obj_dir/tb_rfc_classifier | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"

// ==== rfc_stimulus.txt ====
# W lane sel addr data            (table write, hex)
# P src_ip dst_ip src_port dst_port expected_rule   (packet, hex)
W 0 0 000 0000
W 0 0 001 0001
W 0 1 000 0000
W 0 2 000 0000
W 0 3 000 0000
W 0 4 000 0000
W 0 5 000 0000
W 0 5 001 0000
W 0 6 000 0000
W 0 6 014 0001
W 0 7 000 0000
W 0 8 000 ffff
W 0 8 008 0005
W 1 0 000 0000
W 1 0 001 0000
W 1 1 000 0000
W 1 2 000 0000
W 1 3 000 0000
W 1 4 000 0000
W 1 5 000 0000
W 1 5 001 0001
W 1 6 000 0000
W 1 6 001 0001
W 1 7 000 0000
W 1 8 000 ffff
W 1 8 006 0009
P ab010000 00000000 0000 0000 0005
P 00000000 00000000 0000 0001 0009
P 12010000 00000000 0000 7701 0005
P 00000000 00000000 0000 0000 ffff
P 00010000 00005500 1100 0200 0005
P 00000000 00005500 1100 3301 0009
P 00000000 00000000 1100 4400 ffff
P ff010000 00000000 0000 0001 0005
P 7f000000 00000000 0000 0000 ffff
P 00000000 00000000 0000 ff01 0009
P 5501000f 00000000 0000 0000 0005
P 00020000 00000000 0000 0000 ffff
